// File: Makefile
# Verilator flow for the no-ready stream slave

TOP = tb_st_nordy_slave
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -Mdir obj_dir

# The run target fails unless the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
src/llink_pkg.sv
src/llink_delay_timer.sv
src/llink_sync_fsm.sv
src/st_rx_unpack.sv
src/st_rx_user_if.sv
src/st_nordy_slave_top.sv
verif/tb_st_nordy_slave.sv

// File: src/llink_delay_timer.sv
`timescale 1ns/1ps

module llink_delay_timer (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             load,
  input  llink_pkg::dly_t  load_value,
  output logic             done,
  output logic             busy
);

  import llink_pkg::*;

  // Remaining cycles until expiry
  dly_t cnt;

  ////////////////////////////////////////
  // Down-counter

  // Load always wins, so a reload restarts the count
  // Counter parks at zero once it has expired
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      busy <= 1'b0;
    end else if (load) begin
      cnt  <= load_value;
      busy <= 1'b1;
    end else if (busy) begin
      if (cnt == '0) begin
        // Go idle on the expiry cycle
        busy <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // One-cycle pulse on the last counted cycle
  // Load in cycle t gives done in cycle t + load_value + 1
  assign done = busy && (cnt == '0);

  ////////////////////////////////////////
  // Checks

  // Still counting above one means no expiry next cycle
  a_no_early_done : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (busy && (cnt > dly_t'(1)) && !load) |=> !done
  );

endmodule

// File: src/llink_pkg.sv
package llink_pkg;

  ////////////////////////////////////////
  // PHY lane geometry

  // Full lane and one half-lane
  localparam int PHY_W          = 80;
  localparam int HALF_W         = 40;

  // Strobe and marker slots sit at the same place in either half
  localparam int STB_BIT        = 1;
  localparam int MRK_BIT        = 39;

  // Payload left in a half once strobe and marker are removed
  localparam int HALF_PAYLOAD_W = 38;

  ////////////////////////////////////////
  // Stream word layout

  localparam int WORD_W         = 74;
  localparam int DATA_W         = 64;
  localparam int KEEP_W         = 8;

  // Field positions inside a packed word
  localparam int TDATA_LSB      = 0;
  localparam int TKEEP_LSB      = 64;
  localparam int TLAST_BIT      = 72;
  localparam int TVALID_BIT     = 73;

  ////////////////////////////////////////
  // Control and debug

  localparam int DLY_W          = 16;
  localparam int STATUS_W       = 32;

  typedef logic [PHY_W-1:0]  phy_t;
  typedef logic [WORD_W-1:0] st_word_t;
  typedef logic [DLY_W-1:0]  dly_t;

  // Link bring-up sequence
  typedef enum logic [2:0] {
    OFFLINE,
    WAIT_TX,
    TX_ON,
    WAIT_RX,
    LINK_UP
  } sync_state_e;

endpackage

// File: src/llink_sync_fsm.sv
`timescale 1ns/1ps

module llink_sync_fsm (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             tx_online,
  input  logic             rx_online,
  input  llink_pkg::dly_t  delay_x_value,
  input  llink_pkg::dly_t  delay_y_value,
  input  llink_pkg::dly_t  delay_z_value,
  input  logic             tx_stb_userbit,
  input  logic             tx_mrk_userbit,
  output logic             dly_load,
  output llink_pkg::dly_t  dly_value,
  input  logic             dly_done,
  output logic             stb_load,
  input  logic             stb_done,
  output logic             tx_online_delay,
  output logic             rx_online_delay,
  output logic             tx_auto_stb_userbit,
  output logic             tx_auto_mrk_userbit
);

  import llink_pkg::*;

  sync_state_e state;
  sync_state_e state_nxt;

  // High for the first cycle spent in a new state
  logic entry;
  logic stb_start;
  logic stb_periodic;

  ////////////////////////////////////////
  // Next state

  always_comb begin
    state_nxt = state;
    case (state)
      OFFLINE: if (tx_online) state_nxt = WAIT_TX;
      // Ignore a stale done in the cycle the timer gets reloaded
      WAIT_TX: if (dly_done && !entry) state_nxt = TX_ON;
      TX_ON:   if (rx_online) state_nxt = WAIT_RX;
      WAIT_RX: if (dly_done && !entry) state_nxt = LINK_UP;
      LINK_UP: state_nxt = LINK_UP;
      default: state_nxt = OFFLINE;
    endcase
    // Transmit loss overrides everything
    if (!tx_online) begin
      state_nxt = OFFLINE;
    end
  end

  // State, entry flag and the two online levels
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      state           <= OFFLINE;
      entry           <= 1'b0;
      tx_online_delay <= 1'b0;
      rx_online_delay <= 1'b0;
    end else begin
      state           <= state_nxt;
      entry           <= (state_nxt != state);
      tx_online_delay <= (state_nxt == TX_ON) || (state_nxt == WAIT_RX) ||
                         (state_nxt == LINK_UP);
      rx_online_delay <= (state_nxt == LINK_UP);
    end
  end

  ////////////////////////////////////////
  // Bring-up delay timer

  // Loaded once on entry to either wait state
  assign dly_load  = entry && ((state == WAIT_TX) || (state == WAIT_RX));
  assign dly_value = (state == WAIT_TX) ? delay_x_value : delay_y_value;

  ////////////////////////////////////////
  // Strobe period timer

  // First cycle of TX_ON starts the period
  assign stb_start    = entry && (state == TX_ON);
  // Any done seen on the start cycle is left over from a previous link
  assign stb_periodic = tx_online_delay && stb_done && !stb_start;
  assign stb_load     = tx_online_delay && (stb_start || stb_done);

  // User strobe merges with the periodic one
  assign tx_auto_stb_userbit = tx_online_delay && (stb_periodic || tx_stb_userbit);
  // Marker rides only on strobe cycles
  assign tx_auto_mrk_userbit = tx_auto_stb_userbit && tx_mrk_userbit;

  ////////////////////////////////////////
  // Checks

  // Nonzero bring-up delay never expires right after its load
  a_dly_not_early : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (dly_load && (dly_value != '0)) |=> !dly_done
  );

  // Same for every strobe period reload
  a_stb_not_early : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (stb_load && (delay_z_value != '0)) |=> !stb_done
  );

endmodule

// File: src/st_nordy_slave_top.sv
`timescale 1ns/1ps

module st_nordy_slave_top (
  input  logic                             clk_wr,
  input  logic                             rst_n,

  // Link control
  input  logic                             tx_online,
  input  logic                             rx_online,

  // PHY lanes
  input  llink_pkg::phy_t                  rx_phy0,
  output llink_pkg::phy_t                  tx_phy0,

  // Configuration
  input  logic                             m_gen2_mode,
  input  llink_pkg::dly_t                  delay_x_value,
  input  llink_pkg::dly_t                  delay_y_value,
  input  llink_pkg::dly_t                  delay_z_value,
  input  logic                             tx_stb_userbit,
  input  logic                             tx_mrk_userbit,

  // User stream
  output logic [llink_pkg::KEEP_W-1:0]     user_tkeep,
  output logic [llink_pkg::DATA_W-1:0]     user_tdata,
  output logic                             user_tlast,
  output logic                             user_tvalid,

  // Debug
  output logic [llink_pkg::STATUS_W-1:0]   rx_st_debug_status
);

  import llink_pkg::*;

  ////////////////////////////////////////
  // Internal wiring

  // Sync to timers
  logic     dly_load;
  dly_t     dly_value;
  logic     dly_done;
  logic     stb_load;
  logic     stb_done;

  // Sync to data path
  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     tx_auto_stb_userbit;
  logic     tx_auto_mrk_userbit;

  // Unpack to user stage
  st_word_t rx_st_data;
  logic     rx_st_push;
  logic [15:0] pkt_count;

  ////////////////////////////////////////
  // Bring-up sequencing

  llink_sync_fsm sync_fsm_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .dly_load            (dly_load),
    .dly_value           (dly_value),
    .dly_done            (dly_done),
    .stb_load            (stb_load),
    .stb_done            (stb_done),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  // Shared by delay_x and delay_y
  llink_delay_timer dly_timer_i (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .load       (dly_load),
    .load_value (dly_value),
    .done       (dly_done),
    .busy       ()
  );

  // Strobe period, always delay_z
  llink_delay_timer stb_timer_i (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .load       (stb_load),
    .load_value (delay_z_value),
    .done       (stb_done),
    .busy       ()
  );

  ////////////////////////////////////////
  // Data path

  st_rx_unpack rx_unpack_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .m_gen2_mode    (m_gen2_mode),
    .rx_phy0        (rx_phy0),
    .tx_online      (tx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy0        (tx_phy0),
    .rx_st_data     (rx_st_data),
    .rx_st_push     (rx_st_push)
  );

  st_rx_user_if user_if_i (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .rx_online   (rx_online_delay),
    .rx_st_data  (rx_st_data),
    .rx_st_push  (rx_st_push),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast),
    .user_tvalid (user_tvalid),
    .pkt_count   (pkt_count)
  );

  // Online levels at 19 and 18, packet count at the bottom
  assign rx_st_debug_status = {12'h0, tx_online_delay, rx_online_delay, 2'b00, pkt_count};

endmodule

// File: src/st_rx_unpack.sv
`timescale 1ns/1ps

module st_rx_unpack (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 m_gen2_mode,
  input  llink_pkg::phy_t      rx_phy0,
  input  logic                 tx_online,
  input  logic                 tx_stb_userbit,
  input  logic                 tx_mrk_userbit,
  output llink_pkg::phy_t      tx_phy0,
  output llink_pkg::st_word_t  rx_st_data,
  output logic                 rx_st_push
);

  import llink_pkg::*;

  // Strip strobe and marker, keep the rest in ascending order
  function automatic logic [HALF_PAYLOAD_W-1:0] half_payload(
    input logic [HALF_W-1:0] half
  );
    return {half[MRK_BIT-1:STB_BIT+1], half[STB_BIT-1:0]};
  endfunction

  phy_t                      rx_phy_q;
  logic [HALF_PAYLOAD_W-1:0] lo_pl;
  logic [HALF_PAYLOAD_W-1:0] hi_pl;
  logic [HALF_PAYLOAD_W-1:0] first_pl;
  logic                      first_vld;
  logic                      rx_mrk;
  logic                      push_nxt;
  st_word_t                  word_gen2;
  st_word_t                  word_gen1;
  phy_t                      tx_lane;

  ////////////////////////////////////////
  // Receive input stage

  // One register stage on the received lane
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_phy_q <= '0;
    end else begin
      rx_phy_q <= rx_phy0;
    end
  end

  assign lo_pl  = half_payload(rx_phy_q[HALF_W-1:0]);
  assign hi_pl  = half_payload(rx_phy_q[PHY_W-1:HALF_W]);
  assign rx_mrk = rx_phy_q[MRK_BIT];

  // Gen2 uses both halves of one beat
  assign word_gen2 = {hi_pl[WORD_W-HALF_PAYLOAD_W-1:0], lo_pl};
  // Gen1 uses the lower half of two beats with the marker beat on top
  assign word_gen1 = {lo_pl[WORD_W-HALF_PAYLOAD_W-1:0], first_pl};

  ////////////////////////////////////////
  // Gen1 beat pairing

  // Unmarked beat becomes the first half, marked beat closes the word
  // A marked beat with nothing stored is dropped, which realigns
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      first_vld <= 1'b0;
    end else begin
      first_vld <= !m_gen2_mode && !rx_mrk;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!m_gen2_mode && !rx_mrk) begin
      first_pl <= lo_pl;
    end
  end

  ////////////////////////////////////////
  // Word output

  assign push_nxt = m_gen2_mode || (rx_mrk && first_vld);

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_st_push <= 1'b0;
    end else begin
      rx_st_push <= push_nxt;
    end
  end

  // Word only moves on a push
  always_ff @(posedge clk_wr) begin
    if (push_nxt) begin
      rx_st_data <= m_gen2_mode ? word_gen2 : word_gen1;
    end
  end

  ////////////////////////////////////////
  // Transmit lane

  // Strobe and marker go in the lower half with everything else idle
  always_comb begin
    tx_lane          = '0;
    tx_lane[STB_BIT] = tx_online && tx_stb_userbit;
    tx_lane[MRK_BIT] = tx_online && tx_mrk_userbit;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_lane;
    end
  end

  ////////////////////////////////////////
  // Checks

  // Gen1 never pushes on two back to back cycles
  a_gen1_one_push : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (rx_st_push && !m_gen2_mode) |=> (!rx_st_push || m_gen2_mode)
  );

endmodule

// File: src/st_rx_user_if.sv
`timescale 1ns/1ps

module st_rx_user_if (
  input  logic                            clk_wr,
  input  logic                            rst_n,
  input  logic                            rx_online,
  input  llink_pkg::st_word_t             rx_st_data,
  input  logic                            rx_st_push,
  output logic [llink_pkg::DATA_W-1:0]    user_tdata,
  output logic [llink_pkg::KEEP_W-1:0]    user_tkeep,
  output logic                            user_tlast,
  output logic                            user_tvalid,
  output logic [15:0]                     pkt_count
);

  import llink_pkg::*;

  // Word is handed to the user this cycle
  logic deliver;

  // Drop anything arriving before the receive side is up
  assign deliver = rx_st_push && rx_st_data[TVALID_BIT] && rx_online;

  ////////////////////////////////////////
  // User output register

  // Fields read as zero whenever nothing is delivered
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      user_tvalid <= 1'b0;
      user_tdata  <= '0;
      user_tkeep  <= '0;
      user_tlast  <= 1'b0;
    end else begin
      user_tvalid <= deliver;
      user_tdata  <= deliver ? rx_st_data[TDATA_LSB +: DATA_W] : '0;
      user_tkeep  <= deliver ? rx_st_data[TKEEP_LSB +: KEEP_W] : '0;
      user_tlast  <= deliver && rx_st_data[TLAST_BIT];
    end
  end

  ////////////////////////////////////////
  // Packet counter

  // Counts delivered packet ends and wraps at 16 bits
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      pkt_count <= '0;
    end else if (user_tvalid && user_tlast) begin
      pkt_count <= pkt_count + 1'b1;
    end
  end

endmodule

// File: verif/tb_st_nordy_slave.sv
`timescale 1ns/1ps

module tb_st_nordy_slave;

  import llink_pkg::*;

  ////////////////////////////////////////
  // Constants and stimulus table

  localparam dly_t DLY_X  = 16'd5;
  localparam dly_t DLY_Y  = 16'd3;
  localparam dly_t DLY_Z  = 16'd6;
  localparam int   N_ROWS = 10;

  // One stream word per row
  typedef struct packed {
    logic       gen2;
    logic [7:0] keep;
    logic       last;
    logic       valid;
    logic       pre;   // sent while receive is still down
  } row_t;

  row_t rows [N_ROWS] = '{
    '{1'b1, 8'hff, 1'b1, 1'b1, 1'b1},
    '{1'b0, 8'h0f, 1'b1, 1'b1, 1'b1},
    '{1'b1, 8'hff, 1'b0, 1'b1, 1'b0},
    '{1'b1, 8'hff, 1'b0, 1'b1, 1'b0},
    '{1'b1, 8'h0f, 1'b1, 1'b1, 1'b0},
    '{1'b1, 8'hff, 1'b1, 1'b0, 1'b0},
    '{1'b0, 8'hff, 1'b0, 1'b1, 1'b0},
    '{1'b0, 8'h03, 1'b1, 1'b1, 1'b0},
    '{1'b1, 8'h01, 1'b1, 1'b1, 1'b0},
    '{1'b0, 8'h80, 1'b1, 1'b1, 1'b0}
  };

  // DUT ports
  logic                clk_wr = 1'b0;
  logic                rst_n;
  logic                tx_online;
  logic                rx_online;
  phy_t                rx_phy0;
  logic                m_gen2_mode;
  dly_t                delay_x_value;
  dly_t                delay_y_value;
  dly_t                delay_z_value;
  logic                tx_stb_userbit;
  logic                tx_mrk_userbit;
  phy_t                tx_phy0;
  logic [KEEP_W-1:0]   user_tkeep;
  logic [DATA_W-1:0]   user_tdata;
  logic                user_tlast;
  logic                user_tvalid;
  logic [STATUS_W-1:0] rx_st_debug_status;

  // Reference model state
  int          cyc;
  int          n_checks;
  int          n_val_err;
  int          n_other_err;
  int          pkt_exp;
  logic        tx_model_on;
  int          tx_rise_cyc;
  int          tx_stop_cyc;
  int          stb_due;
  logic [63:0] rng_state;
  // Expected user word keyed by cycle
  st_word_t    exp_user [int];

  st_nordy_slave_top DUT (.*);

  always #20 clk_wr = ~clk_wr;

  ////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    logic [63:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 7);
    s = s ^ (s << 17);
    return s;
  endfunction

  // Payload fills every bit but strobe and marker in ascending order
  function automatic logic [HALF_W-1:0] spread_half(input logic [HALF_PAYLOAD_W-1:0] pl,
                                                    input logic mrk);
    logic [HALF_W-1:0] half;
    int j;
    half = '0;
    j = 0;
    for (int b = 0; b < HALF_W; b++) begin
      if (b == MRK_BIT) begin
        half[b] = mrk;
      end else if (b != STB_BIT) begin
        half[b] = pl[j];
        j++;
      end
    end
    return half;
  endfunction

  function automatic st_word_t make_word(input logic [DATA_W-1:0] data,
                                         input logic [KEEP_W-1:0] keep,
                                         input logic last,
                                         input logic valid);
    st_word_t w;
    w = '0;
    w[TDATA_LSB +: DATA_W] = data;
    w[TKEEP_LSB +: KEEP_W] = keep;
    w[TLAST_BIT]  = last;
    w[TVALID_BIT] = valid;
    return w;
  endfunction

  // Gen2 is one lane, gen1 is two lower-half beats with the marker last
  function automatic phy_t pack_lane(input st_word_t w, input logic gen2, input logic second);
    logic [HALF_PAYLOAD_W-1:0] lo_pl;
    logic [HALF_PAYLOAD_W-1:0] hi_pl;
    phy_t lane;
    lo_pl = w[HALF_PAYLOAD_W-1:0];
    // Top two payload bits of the upper part carry nothing
    hi_pl = {2'b11, w[WORD_W-1:HALF_PAYLOAD_W]};
    lane  = '0;
    if (gen2) begin
      lane = {spread_half(hi_pl, 1'b0), spread_half(lo_pl, 1'b0)};
    end else if (second) begin
      lane[HALF_W-1:0] = spread_half(hi_pl, 1'b1);
    end else begin
      lane[HALF_W-1:0] = spread_half(lo_pl, 1'b0);
    end
    return lane;
  endfunction

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_word(input string name, input st_word_t act, input st_word_t exp);
    n_checks++;
    if (act !== exp) begin
      n_val_err++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at cycle %0d", name, act, exp, cyc);
    end
  endtask

  task automatic check_phy(input string name, input phy_t act, input phy_t exp);
    n_checks++;
    if (act !== exp) begin
      n_val_err++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at cycle %0d", name, act, exp, cyc);
    end
  endtask

  task automatic check_status(input string name, input logic [STATUS_W-1:0] act,
                              input logic [STATUS_W-1:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_val_err++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at cycle %0d", name, act, exp, cyc);
    end
  endtask

  task automatic check_cycles(input string name, input int act, input int exp);
    n_checks++;
    if (act != exp) begin
      n_val_err++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
    end
  endtask

  ////////////////////////////////////////
  // Cycle step with per-cycle checks

  // Outputs are sampled 2 ns after the edge before new inputs go out
  task automatic step();
    st_word_t act_word;
    st_word_t exp_word;
    phy_t     exp_phy;
    logic     tx_live;
    logic     exp_stb;
    @(posedge clk_wr);
    #2;
    cyc++;
    act_word = {user_tvalid, user_tlast, user_tkeep, user_tdata};
    exp_word = exp_user.exists(cyc) ? exp_user[cyc] : '0;
    check_word("user_{tvalid,tlast,tkeep,tdata}", act_word, exp_word);
    // Transmit online during the cycle that just ended
    tx_live = tx_model_on && (cyc - 1 >= tx_rise_cyc) && (cyc <= tx_stop_cyc);
    exp_stb = tx_live && tx_stb_userbit;
    if (tx_live && (cyc == stb_due)) begin
      exp_stb = 1'b1;
      stb_due = stb_due + int'(DLY_Z) + 1;
    end
    exp_phy = '0;
    exp_phy[STB_BIT] = exp_stb;
    exp_phy[MRK_BIT] = exp_stb && tx_mrk_userbit;
    check_phy("tx_phy0", tx_phy0, exp_phy);
  endtask

  task automatic wait_status_bit(input int idx, input int limit, input string what,
                                 output logic ok);
    int n;
    n = 0;
    while ((rx_st_debug_status[idx] !== 1'b1) && (n < limit)) begin
      step();
      n++;
    end
    ok = (rx_st_debug_status[idx] === 1'b1);
    if (!ok) begin
      n_other_err++;
      $display("Timeout: %s did not rise within %0d cycles", what, limit);
    end
  endtask

  task automatic send_row(input int idx);
    row_t     r;
    st_word_t w;
    r = rows[idx];
    rng_state = xorshift64(rng_state);
    w = make_word(rng_state, r.keep, r.last, r.valid);
    // Mode flips only behind an idle beat in the old mode
    if (r.gen2 != m_gen2_mode) begin
      rx_phy0 = '0;
      step();
      m_gen2_mode = r.gen2;
    end
    if (!r.gen2) begin
      // Lone unmarked beat that the next beat overwrites
      rng_state = xorshift64(rng_state);
      rx_phy0 = {rng_state[63:24], rng_state[39:0]};
      rx_phy0[MRK_BIT] = 1'b0;
      step();
      rx_phy0 = pack_lane(w, 1'b0, 1'b0);
      step();
      rx_phy0 = pack_lane(w, 1'b0, 1'b1);
    end else begin
      rx_phy0 = pack_lane(w, 1'b1, 1'b0);
    end
    // Sampled on the next edge, on the user port two edges later
    if (!r.pre && r.valid) begin
      exp_user[cyc + 3] = w;
      if (r.last) begin
        pkt_exp++;
      end
    end
    step();
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin
    int   t0;
    logic ok;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    rx_phy0        = '0;
    m_gen2_mode    = 1'b0;
    delay_x_value  = DLY_X;
    delay_y_value  = DLY_Y;
    delay_z_value  = DLY_Z;
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = 1'b0;
    cyc            = 0;
    n_checks       = 0;
    n_val_err      = 0;
    n_other_err    = 0;
    pkt_exp        = 0;
    tx_model_on    = 1'b0;
    tx_rise_cyc    = 0;
    tx_stop_cyc    = 1 << 30;
    stb_due        = 0;
    rng_state      = 64'd11;

    repeat (4) step();
    rst_n = 1'b1;
    step();
    check_status("rx_st_debug_status", rx_st_debug_status, 32'h0);

    // Transmit bring-up where the strobe period starts with the online level
    tx_online   = 1'b1;
    t0          = cyc;
    tx_model_on = 1'b1;
    tx_rise_cyc = cyc + int'(DLY_X) + 3;
    stb_due     = tx_rise_cyc + int'(DLY_Z) + 2;
    wait_status_bit(19, int'(DLY_X) + 20, "tx_online_delay", ok);
    if (ok) begin
      check_cycles("tx_online_delay latency", cyc - t0 - 1, int'(DLY_X) + 2);
    end
    check_status("rx_st_debug_status", rx_st_debug_status, 32'h0008_0000);

    // Periodic strobes, two user strobes, a marker window
    for (int i = 0; i < 30; i++) begin
      tx_stb_userbit = (i == 4) || (i == 13);
      tx_mrk_userbit = (i >= 10) && (i < 20);
      step();
    end
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = 1'b0;

    // Words ahead of receive bring-up must vanish
    for (int i = 0; i < N_ROWS; i++) begin
      if (rows[i].pre) begin
        send_row(i);
      end
    end
    rx_phy0 = '0;
    repeat (4) step();

    rx_online = 1'b1;
    t0        = cyc;
    wait_status_bit(18, int'(DLY_Y) + 20, "rx_online_delay", ok);
    if (ok) begin
      check_cycles("rx_online_delay latency", cyc - t0 - 1, int'(DLY_Y) + 2);
    end
    check_status("rx_st_debug_status", rx_st_debug_status, 32'h000c_0000);

    for (int i = 0; i < N_ROWS; i++) begin
      if (!rows[i].pre) begin
        send_row(i);
      end
    end
    rx_phy0 = '0;
    repeat (5) step();
    check_status("rx_st_debug_status", rx_st_debug_status,
                 {12'h0, 1'b1, 1'b1, 2'b00, 16'(pkt_exp)});

    // Link drop clears both levels on the next edge
    tx_online   = 1'b0;
    tx_stop_cyc = cyc + 1;
    step();
    check_status("rx_st_debug_status", rx_st_debug_status, {16'h0, 16'(pkt_exp)});
    repeat (3) step();

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             n_checks, n_val_err, n_other_err);
    if ((n_val_err == 0) && (n_other_err == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
